/* Bender.yml */
package:
  name: decode_stage

sources:
  - hdl/dec_pkg.sv
  - hdl/instr_decoder.sv
  - hdl/imm_decoder.sv
  - hdl/operand_select.sv
  - hdl/stage_register.sv
  - hdl/decode_stage.sv
  - target: test
    files:
      - bench/decode_stage_tb.sv

/* bench/decode_stage_tb.sv */
`timescale 1ns/1ns

module decode_stage_tb;

    localparam int MAX_RECORDS = 64;
    localparam int WAIT_LIMIT  = 100;
    localparam int N_COLS      = 14;

    // Record columns
    // ------------------------------
    localparam int C_KIND  = 0;     // 0 word, 1 redirect, 2 flush
    localparam int C_INSTR = 1;     // Redirect target for kind 1
    localparam int C_FERR  = 2;
    localparam int C_RS1D  = 3;
    localparam int C_RS2D  = 4;
    localparam int C_RS1A  = 5;
    localparam int C_RS2A  = 6;
    localparam int C_RD    = 7;     // Then uop, fu, trap, A, B, C

    logic                      g_clk;
    logic                      g_resetn;
    logic                      i_valid;
    logic [dec_pkg::ILEN-1:0]  i_instr;
    logic                      i_fetch_err;
    logic                      o_busy;
    logic                      i_flush;
    logic                      i_cf_req;
    logic [dec_pkg::XLEN-1:0]  i_cf_target;
    logic [dec_pkg::REG_W-1:0] o_rs1_addr;
    logic [dec_pkg::REG_W-1:0] o_rs2_addr;
    logic [dec_pkg::XLEN-1:0]  i_rs1_rdata;
    logic [dec_pkg::XLEN-1:0]  i_rs2_rdata;
    logic                      o_valid;
    logic                      i_busy;
    logic [dec_pkg::REG_W-1:0] o_rd;
    logic [dec_pkg::XLEN-1:0]  o_opr_a;
    logic [dec_pkg::XLEN-1:0]  o_opr_b;
    logic [dec_pkg::XLEN-1:0]  o_opr_c;
    dec_pkg::uop_e             o_uop;
    dec_pkg::fu_e              o_fu;
    logic                      o_trap;
    logic [dec_pkg::ILEN-1:0]  o_instr;

    logic [31:0] rec [0:MAX_RECORDS-1][0:N_COLS-1];
    logic [31:0] snap [0:7];        // Outputs seen in a stalled cycle
    logic [31:0] lfsr_state;
    logic        held;
    int          n_records;
    int          error_count;
    int          timeout_count;
    int          pending [$];       // Accepted records, oldest first

    decode_stage u_decode_stage (
        .g_clk       (g_clk),
        .g_resetn    (g_resetn),
        .i_valid     (i_valid),
        .i_instr     (i_instr),
        .i_fetch_err (i_fetch_err),
        .o_busy      (o_busy),
        .i_flush     (i_flush),
        .i_cf_req    (i_cf_req),
        .i_cf_target (i_cf_target),
        .o_rs1_addr  (o_rs1_addr),
        .o_rs2_addr  (o_rs2_addr),
        .i_rs1_rdata (i_rs1_rdata),
        .i_rs2_rdata (i_rs2_rdata),
        .o_valid     (o_valid),
        .i_busy      (i_busy),
        .o_rd        (o_rd),
        .o_opr_a     (o_opr_a),
        .o_opr_b     (o_opr_b),
        .o_opr_c     (o_opr_c),
        .o_uop       (o_uop),
        .o_fu        (o_fu),
        .o_trap      (o_trap),
        .o_instr     (o_instr)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0]; // Taps 32, 22, 2, 1
        return {s[30:0], fb};
    endfunction

    function automatic logic [31:0] out_field(input int k);
        logic [31:0] v;
        case (k)
            0:       v = {27'd0, o_rd};
            1:       v = {27'd0, o_uop};
            2:       v = {30'd0, o_fu};
            3:       v = {31'd0, o_trap};
            4:       v = o_opr_a;
            5:       v = o_opr_b;
            6:       v = o_opr_c;
            default: v = o_instr;
        endcase
        return v;
    endfunction

    function automatic string field_name(input int k);
        string s;
        case (k)
            0:       s = " o_rd";
            1:       s = " o_uop";
            2:       s = " o_fu";
            3:       s = " o_trap";
            4:       s = " o_opr_a";
            5:       s = " o_opr_b";
            6:       s = " o_opr_c";
            default: s = " o_instr";
        endcase
        return s;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            error_count++;
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic load_records();
        int          fd;
        int          cnt;
        string       line;
        logic [31:0] kind, instr, ferr, rs1d, rs2d, rs1a, rs2a;
        logic [31:0] rd, uop, fu, trap, opr_a, opr_b, opr_c;
        n_records = 0;
        fd = $fopen("bench/decode_testdata.txt", "r");
        if (fd == 0) begin
            error_count++;
            $display("Could not open the stimulus file bench/decode_testdata.txt");
        end else begin
            while ($fgets(line, fd) != 0 && n_records < MAX_RECORDS) begin
                if (line.len() > 1 && line.getc(0) != "#") begin
                    cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                  kind, instr, ferr, rs1d, rs2d, rs1a, rs2a,
                                  rd, uop, fu, trap, opr_a, opr_b, opr_c);
                    if (cnt == N_COLS) begin
                        rec[n_records][0]  = kind;
                        rec[n_records][1]  = instr;
                        rec[n_records][2]  = ferr;
                        rec[n_records][3]  = rs1d;
                        rec[n_records][4]  = rs2d;
                        rec[n_records][5]  = rs1a;
                        rec[n_records][6]  = rs2a;
                        rec[n_records][7]  = rd;
                        rec[n_records][8]  = uop;
                        rec[n_records][9]  = fu;
                        rec[n_records][10] = trap;
                        rec[n_records][11] = opr_a;
                        rec[n_records][12] = opr_b;
                        rec[n_records][13] = opr_c;
                        n_records++;
                    end else begin
                        error_count++;
                        $display("Malformed line in the stimulus file: %s", line);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Cycle helpers
    // ------------------------------
    task automatic tick();
        @(negedge g_clk);
        lfsr_state = lfsr_next(lfsr_state);
        i_busy     = lfsr_state[0];          // One LFSR bit per cycle
    endtask

    task automatic drive_idle();
        i_valid     = 1'b0;
        i_flush     = 1'b0;
        i_cf_req    = 1'b0;
        i_fetch_err = 1'b0;
    endtask

    task automatic observe();
        int    idx;
        int    k;
        string tag;
        logic  expect_valid;
        #1;
        expect_valid = (pending.size() != 0); // An accepted record sits in the register
        check_value("o_valid", expect_valid, o_valid);
        check_value("o_busy", expect_valid && i_busy, o_busy);
        if (held) begin
            for (k = 0; k < 8; k++) begin
                check_value({"hold", field_name(k)}, snap[k], out_field(k));
            end
        end
        held = expect_valid && i_busy;
        for (k = 0; k < 8; k++) begin
            snap[k] = out_field(k);
        end
        if (expect_valid && !i_busy) begin     // Consumed at the next edge
            idx = pending.pop_front();
            tag = $sformatf("record %0d", idx);
            for (k = 0; k < 7; k++) begin
                check_value({tag, field_name(k)}, rec[idx][C_RD + k], out_field(k));
            end
            check_value({tag, field_name(7)}, rec[idx][C_INSTR], out_field(7));
        end
    endtask

    task automatic present_word(input int idx, input logic flush);
        int    waited;
        string tag;
        tag = $sformatf("record %0d", idx);
        tick();
        i_valid     = 1'b1;
        i_flush     = flush;
        i_cf_req    = 1'b0;
        i_instr     = rec[idx][C_INSTR];
        i_fetch_err = rec[idx][C_FERR][0];
        i_rs1_rdata = rec[idx][C_RS1D];
        i_rs2_rdata = rec[idx][C_RS2D];
        observe();
        if (!flush) begin
            check_value({tag, " o_rs1_addr"}, rec[idx][C_RS1A], o_rs1_addr);
            check_value({tag, " o_rs2_addr"}, rec[idx][C_RS2A], o_rs2_addr);
        end
        waited = 0;
        while (o_busy && waited < WAIT_LIMIT) begin
            tick();
            observe();
            waited++;
        end
        if (o_busy) begin
            timeout_count++;
            $display("Timeout: o_busy stayed high for %0d cycles at record %0d",
                     WAIT_LIMIT, idx);
        end else if (!flush) begin
            pending.push_back(idx);
        end
    endtask

    task automatic redirect_pc(input logic [31:0] target);
        tick();
        drive_idle();
        i_cf_req    = 1'b1;                  // Single-cycle strobe
        i_cf_target = target;
        observe();
    endtask

    task automatic drain_outputs();
        int waited;
        waited = 0;
        while ((o_valid || pending.size() != 0) && waited < WAIT_LIMIT) begin
            tick();
            drive_idle();
            observe();
            waited++;
        end
        if (o_valid || pending.size() != 0) begin
            timeout_count++;
            $display("Timeout: o_valid did not clear within %0d cycles, %0d outputs missing",
                     WAIT_LIMIT, pending.size());
        end
    endtask

    initial begin
        g_clk = 1'b0;
        forever #5 g_clk = ~g_clk;
    end

    initial begin
        int r;
        g_resetn      = 1'b0;
        i_valid       = 1'b0;
        i_instr       = '0;
        i_fetch_err   = 1'b0;
        i_flush       = 1'b0;
        i_cf_req      = 1'b0;
        i_cf_target   = '0;
        i_rs1_rdata   = '0;
        i_rs2_rdata   = '0;
        i_busy        = 1'b0;
        lfsr_state    = 32'h1e1b0fed;
        held          = 1'b0;
        error_count   = 0;
        timeout_count = 0;
        load_records();
        repeat (2) @(posedge g_clk);
        @(negedge g_clk);
        g_resetn = 1'b1;
        for (r = 0; r < n_records && timeout_count == 0; r++) begin
            case (rec[r][C_KIND])
                32'd1: redirect_pc(rec[r][C_INSTR]);
                32'd2: begin
                    drain_outputs();             // Flush must not hit a live output
                    if (timeout_count == 0) begin
                        present_word(r, 1'b1);
                    end
                end
                default: present_word(r, 1'b0);
            endcase
        end
        if (timeout_count == 0) begin
            drain_outputs();
        end
        $display("Finished %0d records: %0d errors, %0d timeouts",
                 n_records, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0 && n_records > 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* bench/decode_testdata.txt */
# kind(0 word, 1 redirect, 2 flush) instr_or_target fetch_err rs1_data rs2_data
# expected: rs1_addr rs2_addr rd uop fu trap opr_a opr_b opr_c (all hex)
0 002081b3 0 11111111 22222222 01 02 03 01 1 0 11111111 22222222 00000000
0 407302b3 0 00000010 00000003 06 07 05 02 1 0 00000010 00000003 00000000
0 40a4d433 0 deadbeef 00000004 09 0a 08 0a 1 0 deadbeef 00000004 00000000
0 fff08213 0 00000100 55555555 01 00 04 01 1 0 00000100 ffffffff 00000000
0 4053d313 0 f0000000 55555555 07 00 06 0a 1 0 f0000000 00000005 00000000
0 7ff13493 0 12345678 00000000 02 00 09 07 1 0 12345678 000007ff 00000000
0 12345537 0 aaaaaaaa bbbbbbbb 00 00 0a 04 1 0 00000000 12345000 00000000
0 00001597 0 aaaaaaaa bbbbbbbb 00 00 0b 01 1 0 8000101c 00000000 00000000
0 ffc6a603 0 00002000 bbbbbbbb 0d 00 0c 19 2 0 00002000 fffffffc 00000000
0 01014083 0 40000000 bbbbbbbb 02 00 01 16 2 0 40000000 00000010 00000000
0 00e79323 0 10000000 0000beef 0f 0e 00 1b 2 0 10000000 00000006 0000beef
0 fe21ac23 0 00001000 cafef00d 03 02 00 1c 2 0 00001000 fffffff8 cafef00d
0 00209863 0 00000005 00000006 01 02 00 0c 3 0 00000005 00000006 80000040
0 fe62fce3 0 00000007 00000009 05 06 00 10 3 0 00000007 00000009 8000002c
1 00001000 0 00000000 00000000 00 00 00 00 0 0 00000000 00000000 00000000
0 001000ef 0 aaaaaaaa bbbbbbbb 00 00 01 11 3 0 00000000 00000000 00001800
0 00408067 0 00001234 bbbbbbbb 01 00 00 12 3 0 00001234 00000004 00000000
0 fffff117 0 aaaaaaaa bbbbbbbb 00 00 02 01 1 0 00000008 00000000 00000000
2 00100293 0 00000000 00000000 00 00 00 00 0 0 00000000 00000000 00000000
0 00000073 0 aaaaaaaa bbbbbbbb 00 00 00 13 3 0 00000000 00000000 00000000
0 00100073 0 aaaaaaaa bbbbbbbb 00 00 00 14 3 0 00000000 00000000 00000000
0 002081b3 1 11111111 22222222 00 00 01 00 0 1 00000000 00000000 00000000
0 00003003 0 aaaaaaaa bbbbbbbb 00 00 02 00 0 1 00000000 00000000 00000000
0 ffffffff 1 aaaaaaaa bbbbbbbb 00 00 01 00 0 1 00000000 00000000 00000000
0 00000463 0 00000000 00000000 00 00 00 0b 3 0 00000000 00000000 00001028

/* hdl/dec_pkg.sv */
package dec_pkg;

    localparam int XLEN  = 32;
    localparam int ILEN  = 32;
    localparam int REG_W = 5;

    localparam logic [XLEN-1:0] PC_RESET = 32'h8000_0000;

    // Trap causes, carried on the rd field
    localparam logic [REG_W-1:0] TRAP_IACCESS = 5'd1;
    localparam logic [REG_W-1:0] TRAP_IOPCODE = 5'd2;

    // Operand source codes
    localparam logic [1:0] OPR_ZERO = 2'd0;
    localparam logic [1:0] OPR_REG  = 2'd1; // rs1 for A, rs2 for B and C
    localparam logic [1:0] OPR_IMM  = 2'd2;
    localparam logic [1:0] OPR_PCIM = 2'd3; // PC plus immediate

    typedef enum logic [1:0] {
        FU_NONE,
        FU_ALU,
        FU_LSU,
        FU_CFU
    } fu_e;

    typedef enum logic [4:0] {
        UOP_NONE,
        // ------------------------------
        UOP_ADD, UOP_SUB, UOP_AND, UOP_OR, UOP_XOR,
        UOP_SLT, UOP_SLTU, UOP_SLL, UOP_SRL, UOP_SRA,
        // ------------------------------
        UOP_BEQ, UOP_BNE, UOP_BLT, UOP_BGE, UOP_BLTU, UOP_BGEU,
        UOP_JALI, UOP_JALR, UOP_ECALL, UOP_EBREAK,
        // ------------------------------
        UOP_LB, UOP_LBU, UOP_LH, UOP_LHU, UOP_LW,
        UOP_SB, UOP_SH, UOP_SW
    } uop_e;

    // Major opcodes, bits [6:0] of the word
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OPIMM  = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

endpackage

/* hdl/decode_stage.sv */
`timescale 1ns/1ns

module decode_stage (
    input  logic                      g_clk,
    input  logic                      g_resetn,
    input  logic                      i_valid,
    input  logic [dec_pkg::ILEN-1:0]  i_instr,
    input  logic                      i_fetch_err,
    output logic                      o_busy,
    input  logic                      i_flush,
    input  logic                      i_cf_req,
    input  logic [dec_pkg::XLEN-1:0]  i_cf_target,
    output logic [dec_pkg::REG_W-1:0] o_rs1_addr,
    output logic [dec_pkg::REG_W-1:0] o_rs2_addr,
    input  logic [dec_pkg::XLEN-1:0]  i_rs1_rdata,
    input  logic [dec_pkg::XLEN-1:0]  i_rs2_rdata,
    output logic                      o_valid,
    input  logic                      i_busy,
    output logic [dec_pkg::REG_W-1:0] o_rd,
    output logic [dec_pkg::XLEN-1:0]  o_opr_a,
    output logic [dec_pkg::XLEN-1:0]  o_opr_b,
    output logic [dec_pkg::XLEN-1:0]  o_opr_c,
    output dec_pkg::uop_e             o_uop,
    output dec_pkg::fu_e              o_fu,
    output logic                      o_trap,
    output logic [dec_pkg::ILEN-1:0]  o_instr
);

    dec_pkg::fu_e             dec_fu;
    dec_pkg::uop_e            dec_uop;
    dec_pkg::opcode_e         dec_opcode;
    logic [dec_pkg::REG_W-1:0] dec_rd;
    logic                     dec_trap;
    logic [1:0]               opr_a_src;
    logic [1:0]               opr_b_src;
    logic [1:0]               opr_c_src;
    logic [dec_pkg::XLEN-1:0] imm;
    logic [dec_pkg::XLEN-1:0] pc_imm;
    logic [dec_pkg::XLEN-1:0] opr_a;
    logic [dec_pkg::XLEN-1:0] opr_b;
    logic [dec_pkg::XLEN-1:0] opr_c;

    wire accept = i_valid && !o_busy && !i_flush; // A flushed word moves no PC

    instr_decoder u_instr_decoder (
        .i_instr     (i_instr),
        .i_fetch_err (i_fetch_err),
        .o_fu        (dec_fu),
        .o_uop       (dec_uop),
        .o_opcode    (dec_opcode),
        .o_rs1_addr  (o_rs1_addr),
        .o_rs2_addr  (o_rs2_addr),
        .o_rd        (dec_rd),
        .o_trap      (dec_trap),
        .o_opr_a_src (opr_a_src),
        .o_opr_b_src (opr_b_src),
        .o_opr_c_src (opr_c_src)
    );

    imm_decoder u_imm_decoder (
        .i_instr  (i_instr),
        .i_opcode (dec_opcode),
        .o_imm    (imm),
        .o_pc_imm (pc_imm)
    );

    operand_select u_operand_select (
        .g_clk       (g_clk),
        .g_resetn    (g_resetn),
        .i_advance   (accept),
        .i_cf_req    (i_cf_req),
        .i_cf_target (i_cf_target),
        .i_rs1_rdata (i_rs1_rdata),
        .i_rs2_rdata (i_rs2_rdata),
        .i_imm       (imm),
        .i_pc_imm    (pc_imm),
        .i_opr_a_src (opr_a_src),
        .i_opr_b_src (opr_b_src),
        .i_opr_c_src (opr_c_src),
        .o_opr_a     (opr_a),
        .o_opr_b     (opr_b),
        .o_opr_c     (opr_c)
    );

    stage_register u_stage_register (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .i_valid  (i_valid),
        .i_flush  (i_flush),
        .i_busy   (i_busy),
        .o_busy   (o_busy),
        .o_valid  (o_valid),
        .i_rd     (dec_rd),
        .i_uop    (dec_uop),
        .i_fu     (dec_fu),
        .i_trap   (dec_trap),
        .i_instr  (i_instr),
        .i_opr_a  (opr_a),
        .i_opr_b  (opr_b),
        .i_opr_c  (opr_c),
        .o_rd     (o_rd),
        .o_uop    (o_uop),
        .o_fu     (o_fu),
        .o_trap   (o_trap),
        .o_instr  (o_instr),
        .o_opr_a  (o_opr_a),
        .o_opr_b  (o_opr_b),
        .o_opr_c  (o_opr_c)
    );

endmodule

/* hdl/imm_decoder.sv */
`timescale 1ns/1ns

module imm_decoder (
    input  logic [dec_pkg::ILEN-1:0] i_instr,
    input  dec_pkg::opcode_e         i_opcode,
    output logic [dec_pkg::XLEN-1:0] o_imm,
    output logic [dec_pkg::XLEN-1:0] o_pc_imm
);

    // The five formats plus the shift amount
    // ------------------------------
    wire [dec_pkg::XLEN-1:0] imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
    wire [dec_pkg::XLEN-1:0] imm_s = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
    wire [dec_pkg::XLEN-1:0] imm_b = {{19{i_instr[31]}}, i_instr[31], i_instr[7],
                                      i_instr[30:25], i_instr[11:8], 1'b0};
    wire [dec_pkg::XLEN-1:0] imm_u = {i_instr[31:12], 12'd0};
    wire [dec_pkg::XLEN-1:0] imm_j = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12],
                                      i_instr[20], i_instr[30:21], 1'b0};
    wire [dec_pkg::XLEN-1:0] shamt = {27'd0, i_instr[24:20]};

    wire is_shift = (i_instr[13:12] == 2'b01); // SLLI, SRLI, SRAI

    always_comb begin
        o_imm = '0;
        case (i_opcode)
            dec_pkg::OPC_OPIMM: o_imm = is_shift ? shamt : imm_i;
            dec_pkg::OPC_JALR,
            dec_pkg::OPC_LOAD:  o_imm = imm_i;
            dec_pkg::OPC_STORE: o_imm = imm_s;
            dec_pkg::OPC_LUI:   o_imm = imm_u;
            default:            o_imm = '0;
        endcase
    end

    // Offset added to the PC
    always_comb begin
        case (i_opcode)
            dec_pkg::OPC_AUIPC:  o_pc_imm = imm_u;
            dec_pkg::OPC_JAL:    o_pc_imm = imm_j;
            dec_pkg::OPC_BRANCH: o_pc_imm = imm_b;
            default:             o_pc_imm = '0;
        endcase
    end

endmodule

/* hdl/instr_decoder.sv */
`timescale 1ns/1ns

module instr_decoder (
    input  logic [dec_pkg::ILEN-1:0]  i_instr,
    input  logic                      i_fetch_err,
    output dec_pkg::fu_e              o_fu,
    output dec_pkg::uop_e             o_uop,
    output dec_pkg::opcode_e          o_opcode,
    output logic [dec_pkg::REG_W-1:0] o_rs1_addr,
    output logic [dec_pkg::REG_W-1:0] o_rs2_addr,
    output logic [dec_pkg::REG_W-1:0] o_rd,
    output logic                      o_trap,
    output logic [1:0]                o_opr_a_src,
    output logic [1:0]                o_opr_b_src,
    output logic [1:0]                o_opr_c_src
);

    logic [2:0]     funct3;
    logic [6:0]     funct7;
    dec_pkg::fu_e   fu;
    dec_pkg::uop_e  uop;
    logic           legal;
    logic           has_rd;
    logic [1:0]     src_a;
    logic [1:0]     src_b;
    logic [1:0]     src_c;

    // Shared by the register and immediate ALU forms
    function automatic dec_pkg::uop_e alu_uop(
        input logic [2:0] f3,
        input logic       alt
    );
        dec_pkg::uop_e op;
        case (f3)
            3'd0:    op = alt ? dec_pkg::UOP_SUB : dec_pkg::UOP_ADD;
            3'd1:    op = dec_pkg::UOP_SLL;
            3'd2:    op = dec_pkg::UOP_SLT;
            3'd3:    op = dec_pkg::UOP_SLTU;
            3'd4:    op = dec_pkg::UOP_XOR;
            3'd5:    op = alt ? dec_pkg::UOP_SRA : dec_pkg::UOP_SRL;
            3'd6:    op = dec_pkg::UOP_OR;
            default: op = dec_pkg::UOP_AND;
        endcase
        return op;
    endfunction

    assign funct3   = i_instr[14:12];
    assign funct7   = i_instr[31:25];
    assign o_opcode = dec_pkg::opcode_e'(i_instr[6:0]);

    // Classification
    // ------------------------------
    always_comb begin
        fu     = dec_pkg::FU_NONE;
        uop    = dec_pkg::UOP_NONE;
        legal  = 1'b0;
        has_rd = 1'b0;
        src_a  = dec_pkg::OPR_ZERO;
        src_b  = dec_pkg::OPR_ZERO;
        src_c  = dec_pkg::OPR_ZERO;
        case (o_opcode)
            dec_pkg::OPC_LUI: begin
                fu     = dec_pkg::FU_ALU;
                uop    = dec_pkg::UOP_OR;
                legal  = 1'b1;
                has_rd = 1'b1;
                src_b  = dec_pkg::OPR_IMM;
            end
            dec_pkg::OPC_AUIPC: begin
                fu     = dec_pkg::FU_ALU;
                uop    = dec_pkg::UOP_ADD;
                legal  = 1'b1;
                has_rd = 1'b1;
                src_a  = dec_pkg::OPR_PCIM;
            end
            dec_pkg::OPC_JAL: begin
                fu     = dec_pkg::FU_CFU;
                uop    = dec_pkg::UOP_JALI;
                legal  = 1'b1;
                has_rd = 1'b1;
                src_c  = dec_pkg::OPR_PCIM;
            end
            dec_pkg::OPC_JALR: begin
                fu     = dec_pkg::FU_CFU;
                uop    = dec_pkg::UOP_JALR;
                has_rd = 1'b1;
                legal  = (funct3 == 3'd0);
                src_a  = dec_pkg::OPR_REG;
                src_b  = dec_pkg::OPR_IMM;
            end
            dec_pkg::OPC_BRANCH: begin
                fu    = dec_pkg::FU_CFU;
                legal = (funct3[2:1] != 2'b01); // funct3 2 and 3 unused
                case (funct3)
                    3'd0:    uop = dec_pkg::UOP_BEQ;
                    3'd1:    uop = dec_pkg::UOP_BNE;
                    3'd4:    uop = dec_pkg::UOP_BLT;
                    3'd5:    uop = dec_pkg::UOP_BGE;
                    3'd6:    uop = dec_pkg::UOP_BLTU;
                    default: uop = dec_pkg::UOP_BGEU;
                endcase
                src_a = dec_pkg::OPR_REG;
                src_b = dec_pkg::OPR_REG;
                src_c = dec_pkg::OPR_PCIM;
            end
            dec_pkg::OPC_LOAD: begin
                fu     = dec_pkg::FU_LSU;
                has_rd = 1'b1;
                legal  = (funct3 != 3'd3) && (funct3 < 3'd6);
                case (funct3)
                    3'd0:    uop = dec_pkg::UOP_LB;
                    3'd1:    uop = dec_pkg::UOP_LH;
                    3'd4:    uop = dec_pkg::UOP_LBU;
                    3'd5:    uop = dec_pkg::UOP_LHU;
                    default: uop = dec_pkg::UOP_LW;
                endcase
                src_a = dec_pkg::OPR_REG;
                src_b = dec_pkg::OPR_IMM;
            end
            dec_pkg::OPC_STORE: begin
                fu    = dec_pkg::FU_LSU;
                legal = (funct3 < 3'd3);
                case (funct3)
                    3'd0:    uop = dec_pkg::UOP_SB;
                    3'd1:    uop = dec_pkg::UOP_SH;
                    default: uop = dec_pkg::UOP_SW;
                endcase
                src_a = dec_pkg::OPR_REG;
                src_b = dec_pkg::OPR_IMM;
                src_c = dec_pkg::OPR_REG; // Store data
            end
            dec_pkg::OPC_OPIMM: begin
                fu     = dec_pkg::FU_ALU;
                has_rd = 1'b1;
                uop    = alu_uop(funct3, (funct3 == 3'd5) && i_instr[30]);
                if (funct3 == 3'd1) begin
                    legal = (funct7 == 7'h00);
                end else if (funct3 == 3'd5) begin
                    legal = (funct7 == 7'h00) || (funct7 == 7'h20);
                end else begin
                    legal = 1'b1;
                end
                src_a = dec_pkg::OPR_REG;
                src_b = dec_pkg::OPR_IMM;
            end
            dec_pkg::OPC_OP: begin
                fu     = dec_pkg::FU_ALU;
                has_rd = 1'b1;
                uop    = alu_uop(funct3, i_instr[30]);
                legal  = (funct7 == 7'h00) ||
                         ((funct7 == 7'h20) && (funct3 == 3'd0 || funct3 == 3'd5));
                src_a  = dec_pkg::OPR_REG;
                src_b  = dec_pkg::OPR_REG;
            end
            dec_pkg::OPC_SYSTEM: begin
                fu = dec_pkg::FU_CFU;
                if (i_instr[31:7] == 25'd0) begin
                    uop   = dec_pkg::UOP_ECALL;
                    legal = 1'b1;
                end else if (i_instr[31:7] == {12'd1, 13'd0}) begin
                    uop   = dec_pkg::UOP_EBREAK;
                    legal = 1'b1;
                end
            end
            default: legal = 1'b0;
        endcase
    end

    // Trap override
    // ------------------------------
    assign o_trap      = i_fetch_err || !legal; // Fetch error wins on the cause
    assign o_fu        = o_trap ? dec_pkg::FU_NONE  : fu;
    assign o_uop       = o_trap ? dec_pkg::UOP_NONE : uop;
    assign o_opr_a_src = o_trap ? dec_pkg::OPR_ZERO : src_a;
    assign o_opr_b_src = o_trap ? dec_pkg::OPR_ZERO : src_b;
    assign o_opr_c_src = o_trap ? dec_pkg::OPR_ZERO : src_c;

    assign o_rs1_addr = (o_opr_a_src == dec_pkg::OPR_REG) ? i_instr[19:15] : '0;
    assign o_rs2_addr = (o_opr_b_src == dec_pkg::OPR_REG ||
                         o_opr_c_src == dec_pkg::OPR_REG) ? i_instr[24:20] : '0;

    assign o_rd = i_fetch_err ? dec_pkg::TRAP_IACCESS :
                  o_trap      ? dec_pkg::TRAP_IOPCODE :
                  has_rd      ? i_instr[11:7]         : '0;

endmodule

/* hdl/operand_select.sv */
`timescale 1ns/1ns

module operand_select (
    input  logic                     g_clk,
    input  logic                     g_resetn,
    input  logic                     i_advance,
    input  logic                     i_cf_req,
    input  logic [dec_pkg::XLEN-1:0] i_cf_target,
    input  logic [dec_pkg::XLEN-1:0] i_rs1_rdata,
    input  logic [dec_pkg::XLEN-1:0] i_rs2_rdata,
    input  logic [dec_pkg::XLEN-1:0] i_imm,
    input  logic [dec_pkg::XLEN-1:0] i_pc_imm,
    input  logic [1:0]               i_opr_a_src,
    input  logic [1:0]               i_opr_b_src,
    input  logic [1:0]               i_opr_c_src,
    output logic [dec_pkg::XLEN-1:0] o_opr_a,
    output logic [dec_pkg::XLEN-1:0] o_opr_b,
    output logic [dec_pkg::XLEN-1:0] o_opr_c
);

    logic [dec_pkg::XLEN-1:0] pc;          // Address of the word in decode
    logic [dec_pkg::XLEN-1:0] pc_plus_imm;

    // One multiplexer serves all three operands
    function automatic logic [dec_pkg::XLEN-1:0] opr_mux(
        input logic [1:0]               sel,
        input logic [dec_pkg::XLEN-1:0] reg_val,
        input logic [dec_pkg::XLEN-1:0] imm,
        input logic [dec_pkg::XLEN-1:0] pcim
    );
        logic [dec_pkg::XLEN-1:0] val;
        case (sel)
            dec_pkg::OPR_REG:  val = reg_val;
            dec_pkg::OPR_IMM:  val = imm;
            dec_pkg::OPR_PCIM: val = pcim;
            default:           val = '0;
        endcase
        return val;
    endfunction

    // Program counter
    // ------------------------------
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            pc <= dec_pkg::PC_RESET;
        end else if (i_cf_req) begin
            pc <= i_cf_target;           // Redirect beats increment
        end else if (i_advance) begin
            pc <= pc + 32'd4;
        end
    end

    assign pc_plus_imm = pc + i_pc_imm;

    assign o_opr_a = opr_mux(i_opr_a_src, i_rs1_rdata, i_imm, pc_plus_imm);
    assign o_opr_b = opr_mux(i_opr_b_src, i_rs2_rdata, i_imm, pc_plus_imm);
    assign o_opr_c = opr_mux(i_opr_c_src, i_rs2_rdata, i_imm, pc_plus_imm);

endmodule

/* hdl/stage_register.sv */
`timescale 1ns/1ns

module stage_register (
    input  logic                      g_clk,
    input  logic                      g_resetn,
    input  logic                      i_valid,
    input  logic                      i_flush,
    input  logic                      i_busy,
    output logic                      o_busy,
    output logic                      o_valid,
    input  logic [dec_pkg::REG_W-1:0] i_rd,
    input  dec_pkg::uop_e             i_uop,
    input  dec_pkg::fu_e              i_fu,
    input  logic                      i_trap,
    input  logic [dec_pkg::ILEN-1:0]  i_instr,
    input  logic [dec_pkg::XLEN-1:0]  i_opr_a,
    input  logic [dec_pkg::XLEN-1:0]  i_opr_b,
    input  logic [dec_pkg::XLEN-1:0]  i_opr_c,
    output logic [dec_pkg::REG_W-1:0] o_rd,
    output dec_pkg::uop_e             o_uop,
    output dec_pkg::fu_e              o_fu,
    output logic                      o_trap,
    output logic [dec_pkg::ILEN-1:0]  o_instr,
    output logic [dec_pkg::XLEN-1:0]  o_opr_a,
    output logic [dec_pkg::XLEN-1:0]  o_opr_b,
    output logic [dec_pkg::XLEN-1:0]  o_opr_c
);

    wire load = i_valid && !o_busy;

    // Stalls upstream only while a held word is not taken
    assign o_busy = o_valid && i_busy;

    always_ff @(posedge g_clk) begin
        if (!g_resetn || i_flush) begin
            o_valid <= 1'b0;
        end else if (!o_busy) begin
            o_valid <= i_valid;          // Drops to zero once consumed
        end
    end

    // Payload
    // ------------------------------
    always_ff @(posedge g_clk) begin
        if (load) begin
            o_rd    <= i_rd;
            o_uop   <= i_uop;
            o_fu    <= i_fu;
            o_trap  <= i_trap;
            o_instr <= i_instr;
            o_opr_a <= i_opr_a;
            o_opr_b <= i_opr_b;
            o_opr_c <= i_opr_c;
        end
    end

endmodule

/* list.f */
hdl/dec_pkg.sv
hdl/instr_decoder.sv
hdl/imm_decoder.sv
hdl/operand_select.sv
hdl/stage_register.sv
hdl/decode_stage.sv
bench/decode_stage_tb.sv
